//--- source/modular_pkg.sv
//////////////////////////////
// Arithmetic types shared by the sequencer and the datapath units
// Operand width, opcodes and the operand and request bundles
//////////////////////////////

`default_nettype none

package modular_pkg;

  // Operand width in bits
  localparam int DATA_SIZE = 32;

  // Bits needed to index one operand bit
  localparam int COUNT_SIZE = $clog2(DATA_SIZE);

  // Index of the operand MSB, start of the exponent scan
  localparam logic [COUNT_SIZE-1:0] LAST_BIT = COUNT_SIZE'(DATA_SIZE - 1);

  // Multiplier steps per operation, one per bit of operand_a
  localparam logic [COUNT_SIZE:0] STEP_COUNT = (COUNT_SIZE + 1)'(DATA_SIZE);

  // Neutral element of the exponent loop
  localparam logic [DATA_SIZE-1:0] DATA_ONE = DATA_SIZE'(1);

  // Operation codes as written in CONTROL[1:0]
  typedef enum logic [1:0] {
    MOD_ADD = 2'd0,
    MOD_SUB = 2'd1,
    MOD_MUL = 2'd2,
    MOD_EXP = 2'd3
  } mod_opcode_e;

  // Modulus and both operands, 96 bits
  typedef struct packed {
    logic [DATA_SIZE-1:0] modulus;
    logic [DATA_SIZE-1:0] operand_a;
    logic [DATA_SIZE-1:0] operand_b;
  } mod_operands_t;

  // Full launch request, 98 bits
  typedef struct packed {
    mod_opcode_e   opcode;
    mod_operands_t operands;
  } mod_request_t;

endpackage

`default_nettype wire

//--- source/wishbone_pkg.sv
//////////////////////////////
// Bus side types of the accelerator
// Word address map and Wishbone classic request and response
//////////////////////////////

`default_nettype none

package wishbone_pkg;

  // Word address width, eight slots
  localparam int WB_ADDR_SIZE = 3;

  // Register map
  typedef enum logic [WB_ADDR_SIZE-1:0] {
    REG_MODULUS   = 3'd0,
    REG_OPERAND_A = 3'd1,
    REG_OPERAND_B = 3'd2,
    REG_CONTROL   = 3'd3,
    REG_STATUS    = 3'd4,
    REG_RESULT    = 3'd5
  } reg_address_e;

  // Master to slave, 38 bits
  typedef struct packed {
    logic                              cyc;
    logic                              stb;
    logic                              we;
    logic [WB_ADDR_SIZE-1:0]           adr;
    logic [modular_pkg::DATA_SIZE-1:0] dat;
  } wb_request_t;

  // Slave to master, 33 bits
  typedef struct packed {
    logic                              ack;
    logic [modular_pkg::DATA_SIZE-1:0] dat;
  } wb_response_t;

endpackage

`default_nettype wire

//--- source/modular_register_file.sv
//////////////////////////////
// Wishbone classic slave of the accelerator
// Holds modulus, operands, status and result; launches operations
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module modular_register_file (
  input  logic                              CLK,
  input  logic                              RST,
  input  wishbone_pkg::wb_request_t         bus_request,
  output wishbone_pkg::wb_response_t        bus_response,
  output logic                              start,
  output modular_pkg::mod_request_t         request,
  input  logic                              busy,
  input  logic                              done,
  input  logic [modular_pkg::DATA_SIZE-1:0] result
);

  logic                              access;
  logic                              launch;
  modular_pkg::mod_opcode_e          opcode_q;
  modular_pkg::mod_operands_t        operands_q;
  logic [modular_pkg::DATA_SIZE-1:0] result_q;
  logic                              done_q;
  logic [modular_pkg::DATA_SIZE-1:0] read_data;

  // New access, one per request since ack blocks the second cycle
  assign access = bus_request.cyc & bus_request.stb & ~bus_response.ack;

  // Start bit set, unit idle and no launch already on its way
  assign launch = access & bus_request.we & bus_request.dat[31] & ~busy & ~start &
                  (bus_request.adr == wishbone_pkg::REG_CONTROL);

  assign request = '{opcode: opcode_q, operands: operands_q};

  //////////////////////////////
  // Read mux
  //////////////////////////////
  always_comb begin
    read_data = '0;
    case (wishbone_pkg::reg_address_e'(bus_request.adr))
      wishbone_pkg::REG_MODULUS:   read_data = operands_q.modulus;
      wishbone_pkg::REG_OPERAND_A: read_data = operands_q.operand_a;
      wishbone_pkg::REG_OPERAND_B: read_data = operands_q.operand_b;
      // Last launched opcode in the low bits
      wishbone_pkg::REG_CONTROL:   read_data[1:0] = opcode_q;
      wishbone_pkg::REG_STATUS:    read_data[1:0] = {done_q, busy};
      wishbone_pkg::REG_RESULT:    read_data = result_q;
      default:                     read_data = '0;
    endcase
  end

  //////////////////////////////
  // Bus handshake and registers
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bus_response <= '0;
      start        <= 1'b0;
      opcode_q     <= modular_pkg::MOD_ADD;
      operands_q   <= '0;
      result_q     <= '0;
      done_q       <= 1'b0;
    end else begin
      // Ack one cycle after the sampled strobe, no wait states
      bus_response.ack <= access;
      bus_response.dat <= (access && !bus_request.we) ? read_data : '0;
      start            <= launch;

      if (access && bus_request.we) begin
        case (wishbone_pkg::reg_address_e'(bus_request.adr))
          wishbone_pkg::REG_MODULUS:   operands_q.modulus   <= bus_request.dat;
          wishbone_pkg::REG_OPERAND_A: operands_q.operand_a <= bus_request.dat;
          wishbone_pkg::REG_OPERAND_B: operands_q.operand_b <= bus_request.dat;
          default: ;
        endcase
      end

      // Opcode kept only for accepted launches
      if (launch) begin
        opcode_q <= modular_pkg::mod_opcode_e'(bus_request.dat[1:0]);
      end

      // Sticky done, cleared by a launch
      if (launch) begin
        done_q <= 1'b0;
      end else if (done) begin
        done_q   <= 1'b1;
        result_q <= result;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/modular_sequencer.sv
//////////////////////////////
// Operation sequencer, one operation in flight
// Dispatches add/sub/mul and runs square-and-multiply for exp
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module modular_sequencer (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  modular_pkg::mod_request_t         request,
  output logic                              busy,
  output logic                              done,
  output logic [modular_pkg::DATA_SIZE-1:0] result,
  output logic                              add_start,
  output logic                              add_subtract,
  output modular_pkg::mod_operands_t        add_operands,
  input  logic                              add_ready,
  input  logic [modular_pkg::DATA_SIZE-1:0] add_result,
  output logic                              mul_start,
  output modular_pkg::mod_operands_t        mul_operands,
  input  logic                              mul_ready,
  input  logic [modular_pkg::DATA_SIZE-1:0] mul_result
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_ADD,
    WAIT_MUL,
    EXP_SQUARE,
    EXP_MULTIPLY
  } state_e;

  state_e                              state;
  modular_pkg::mod_request_t           request_q;
  logic [modular_pkg::DATA_SIZE-1:0]   accumulator;
  logic [modular_pkg::COUNT_SIZE-1:0]  bit_index;
  logic                                exponent_bit;

  // Exponent scanned from the MSB
  assign exponent_bit = request_q.operands.operand_b[bit_index];

  // Held through the done cycle so no launch lands before the flag is set
  assign busy   = (state != IDLE) | done;
  assign result = accumulator;

  assign add_subtract = (request_q.opcode == modular_pkg::MOD_SUB);
  assign add_operands = request_q.operands;

  // Multiplier inputs, plain request or exponent loop operands
  always_comb begin
    mul_operands = request_q.operands;
    case (state)
      EXP_SQUARE: begin
        mul_operands.operand_a = accumulator;
        mul_operands.operand_b = accumulator;
      end
      EXP_MULTIPLY: begin
        mul_operands.operand_a = accumulator;
        mul_operands.operand_b = request_q.operands.operand_a;
      end
      default: ;
    endcase
  end

  //////////////////////////////
  // Control FSM
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= IDLE;
      request_q   <= '0;
      accumulator <= '0;
      bit_index   <= '0;
      done        <= 1'b0;
      add_start   <= 1'b0;
      mul_start   <= 1'b0;
    end else begin
      // Strobes last one cycle
      done      <= 1'b0;
      add_start <= 1'b0;
      mul_start <= 1'b0;

      case (state)
        IDLE: begin
          if (start) begin
            request_q <= request;
            case (request.opcode)
              modular_pkg::MOD_ADD, modular_pkg::MOD_SUB: begin
                add_start <= 1'b1;
                state     <= WAIT_ADD;
              end
              modular_pkg::MOD_MUL: begin
                mul_start <= 1'b1;
                state     <= WAIT_MUL;
              end
              default: begin
                // Exp starts from 1 at the exponent MSB
                accumulator <= modular_pkg::DATA_ONE;
                bit_index   <= modular_pkg::LAST_BIT;
                mul_start   <= 1'b1;
                state       <= EXP_SQUARE;
              end
            endcase
          end
        end
        WAIT_ADD: begin
          if (add_ready) begin
            accumulator <= add_result;
            done        <= 1'b1;
            state       <= IDLE;
          end
        end
        WAIT_MUL: begin
          if (mul_ready) begin
            accumulator <= mul_result;
            done        <= 1'b1;
            state       <= IDLE;
          end
        end
        EXP_SQUARE: begin
          if (mul_ready) begin
            accumulator <= mul_result;
            if (exponent_bit) begin
              // Set bit, multiply by the base next
              mul_start <= 1'b1;
              state     <= EXP_MULTIPLY;
            end else if (bit_index == '0) begin
              done  <= 1'b1;
              state <= IDLE;
            end else begin
              bit_index <= bit_index - 1'b1;
              mul_start <= 1'b1;
            end
          end
        end
        EXP_MULTIPLY: begin
          if (mul_ready) begin
            accumulator <= mul_result;
            if (bit_index == '0) begin
              done  <= 1'b1;
              state <= IDLE;
            end else begin
              bit_index <= bit_index - 1'b1;
              mul_start <= 1'b1;
              state     <= EXP_SQUARE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/scalar_modular_adder.sv
//////////////////////////////
// Modular adder and subtractor, one registered stage
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module scalar_modular_adder (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  logic                              subtract,
  input  modular_pkg::mod_operands_t        operands,
  output logic                              ready,
  output logic [modular_pkg::DATA_SIZE-1:0] result
);

  logic [modular_pkg::DATA_SIZE:0] modulus_wide;
  logic [modular_pkg::DATA_SIZE:0] sum;
  logic [modular_pkg::DATA_SIZE:0] difference;
  logic [modular_pkg::DATA_SIZE:0] corrected;

  assign modulus_wide = {1'b0, operands.modulus};

  // Extra MSB holds the carry or the borrow
  assign sum        = {1'b0, operands.operand_a} + {1'b0, operands.operand_b};
  assign difference = {1'b0, operands.operand_a} - {1'b0, operands.operand_b};

  // One correction by the modulus is enough for reduced operands
  always_comb begin
    if (subtract) begin
      corrected = difference[modular_pkg::DATA_SIZE] ? (difference + modulus_wide) : difference;
    end else begin
      corrected = (sum >= modulus_wide) ? (sum - modulus_wide) : sum;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready  <= 1'b0;
      result <= '0;
    end else begin
      ready <= start;
      if (start) begin
        result <= corrected[modular_pkg::DATA_SIZE-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/scalar_modular_multiplier.sv
//////////////////////////////
// Interleaved modular multiplier, MSB first
// Start samples the operands, ready pulses DATA_SIZE+1 cycles later
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module scalar_modular_multiplier (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  modular_pkg::mod_operands_t        operands,
  output logic                              ready,
  output logic [modular_pkg::DATA_SIZE-1:0] result
);

  typedef enum logic {
    IDLE,
    STEP
  } state_e;

  state_e                              state;
  modular_pkg::mod_operands_t          operands_q;
  logic [modular_pkg::DATA_SIZE:0]     accumulator;
  logic [modular_pkg::COUNT_SIZE:0]    step_count;
  logic [modular_pkg::DATA_SIZE+1:0]   modulus_wide;
  logic [modular_pkg::DATA_SIZE+1:0]   doubled_sum;
  logic [modular_pkg::DATA_SIZE+1:0]   first_reduce;
  logic [modular_pkg::DATA_SIZE+1:0]   second_reduce;

  assign modulus_wide = {2'b00, operands_q.modulus};

  // 2*acc + b stays below 3*modulus
  assign doubled_sum = {accumulator, 1'b0} +
                       (operands_q.operand_a[modular_pkg::DATA_SIZE-1] ?
                        {2'b00, operands_q.operand_b} : '0);

  // Two conditional subtractions bring it back under the modulus
  assign first_reduce  = (doubled_sum >= modulus_wide) ? (doubled_sum - modulus_wide)
                                                       : doubled_sum;
  assign second_reduce = (first_reduce >= modulus_wide) ? (first_reduce - modulus_wide)
                                                        : first_reduce;

  //////////////////////////////
  // Iteration FSM
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= IDLE;
      operands_q  <= '0;
      accumulator <= '0;
      step_count  <= '0;
      ready       <= 1'b0;
      result      <= '0;
    end else begin
      ready <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            operands_q  <= operands;
            accumulator <= '0;
            step_count  <= '0;
            state       <= STEP;
          end
        end
        STEP: begin
          if (step_count == modular_pkg::STEP_COUNT) begin
            // All bits consumed
            result <= accumulator[modular_pkg::DATA_SIZE-1:0];
            ready  <= 1'b1;
            state  <= IDLE;
          end else begin
            accumulator          <= second_reduce[modular_pkg::DATA_SIZE:0];
            // Next bit of a moves into the MSB
            operands_q.operand_a <= {operands_q.operand_a[modular_pkg::DATA_SIZE-2:0], 1'b0};
            step_count           <= step_count + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/modular_arithmetic_unit.sv
//////////////////////////////
// Top of the modular arithmetic accelerator
// Wishbone slave, sequencer, adder and multiplier
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module modular_arithmetic_unit (
  input  logic                       CLK,
  input  logic                       RST,
  input  wishbone_pkg::wb_request_t  bus_request,
  output wishbone_pkg::wb_response_t bus_response
);

  // Register file to sequencer
  logic                              start;
  modular_pkg::mod_request_t         request;
  logic                              busy;
  logic                              done;
  logic [modular_pkg::DATA_SIZE-1:0] result;

  // Sequencer to adder
  logic                              add_start;
  logic                              add_subtract;
  modular_pkg::mod_operands_t        add_operands;
  logic                              add_ready;
  logic [modular_pkg::DATA_SIZE-1:0] add_result;

  // Sequencer to multiplier
  logic                              mul_start;
  modular_pkg::mod_operands_t        mul_operands;
  logic                              mul_ready;
  logic [modular_pkg::DATA_SIZE-1:0] mul_result;

  modular_register_file modular_register_file_i (
    .CLK(CLK), .RST(RST),
    .bus_request(bus_request), .bus_response(bus_response),
    .start(start), .request(request),
    .busy(busy), .done(done), .result(result)
  );

  modular_sequencer modular_sequencer_i (
    .CLK(CLK), .RST(RST),
    .start(start), .request(request),
    .busy(busy), .done(done), .result(result),
    .add_start(add_start), .add_subtract(add_subtract), .add_operands(add_operands),
    .add_ready(add_ready), .add_result(add_result),
    .mul_start(mul_start), .mul_operands(mul_operands),
    .mul_ready(mul_ready), .mul_result(mul_result)
  );

  scalar_modular_adder scalar_modular_adder_i (
    .CLK(CLK), .RST(RST),
    .start(add_start), .subtract(add_subtract), .operands(add_operands),
    .ready(add_ready), .result(add_result)
  );

  scalar_modular_multiplier scalar_modular_multiplier_i (
    .CLK(CLK), .RST(RST),
    .start(mul_start), .operands(mul_operands),
    .ready(mul_ready), .result(mul_result)
  );

endmodule

`default_nettype wire

//--- tb/modular_arithmetic_unit_assertions.sv
//////////////////////////////
// Wishbone protocol checks, bound to the accelerator top
// Counts failed assertions for the testbench verdict
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module modular_arithmetic_unit_assertions (
  input logic                       CLK,
  input logic                       RST,
  input wishbone_pkg::wb_request_t  bus_request,
  input wishbone_pkg::wb_response_t bus_response
);

  // Read by the testbench during and at the end of the run
  int failure_count = 0;

  // Ack only answers a strobe seen on the previous edge
  ack_follows_strobe: assert property (@(posedge CLK) disable iff (RST)
    bus_response.ack |-> $past(bus_request.cyc && bus_request.stb))
  else begin
    failure_count++;
    $error("ack raised without a request on the previous cycle");
  end

  // One ack per request, never two in a row
  ack_single_cycle: assert property (@(posedge CLK) disable iff (RST)
    bus_response.ack |=> !bus_response.ack)
  else begin
    failure_count++;
    $error("ack stayed high for two cycles");
  end

  // Quiet bus while in reset
  response_quiet_in_reset: assert property (@(posedge CLK)
    RST |-> (bus_response == '0))
  else begin
    failure_count++;
    $error("bus response not zero during reset");
  end

endmodule

bind modular_arithmetic_unit modular_arithmetic_unit_assertions assertions_i (
  .CLK(CLK),
  .RST(RST),
  .bus_request(bus_request),
  .bus_response(bus_response)
);

`default_nettype wire

//--- tb/modular_arithmetic_unit_tb.sv
//////////////////////////////
// Testbench of the modular arithmetic accelerator
// Wishbone tasks, LCG stimulus, wide-integer reference model
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module modular_arithmetic_unit_tb;

  localparam int BUS_TIMEOUT = 8;
  // Exp runs about 2200 cycles, a poll costs about 3
  localparam int POLL_LIMIT  = 4000;

  logic                       CLK;
  logic                       RST;
  wishbone_pkg::wb_request_t  bus_request;
  wishbone_pkg::wb_response_t bus_response;
  logic [31:0]                lcg_state = 32'd71;

  modular_arithmetic_unit modular_arithmetic_unit_i (
    .CLK(CLK),
    .RST(RST),
    .bus_request(bus_request),
    .bus_response(bus_response)
  );

  // 20 ns clock
  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Watch the bound Wishbone checks
  always @(posedge CLK) begin
    if (modular_arithmetic_unit_i.assertions_i.failure_count != 0) begin
      $display("A bound Wishbone protocol assertion failed");
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // (a op b) mod m, straight from the definition, 64-bit math
  function automatic logic [31:0] reference_result(modular_pkg::mod_opcode_e opcode,
                                                   logic [31:0] modulus, logic [31:0] a,
                                                   logic [31:0] b);
    logic [63:0] m;
    logic [63:0] r;
    logic [63:0] base;
    m = {32'd0, modulus};
    case (opcode)
      modular_pkg::MOD_ADD: r = ({32'd0, a} + b) % m;
      modular_pkg::MOD_SUB: r = ({32'd0, a} + m - b) % m;
      modular_pkg::MOD_MUL: r = ({32'd0, a} * b) % m;
      default: begin
        // Right-to-left binary powering
        r = 64'd1;
        base = {32'd0, a};
        for (int i = 0; i < modular_pkg::DATA_SIZE; i++) begin
          if (b[i]) r = (r * base) % m;
          base = (base * base) % m;
        end
      end
    endcase
    return r[31:0];
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual == expected) else begin
      $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timeout while waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  //////////////////////////////
  // Wishbone master
  //////////////////////////////
  task automatic bus_access(logic write, wishbone_pkg::reg_address_e address,
                            logic [31:0] data_in, output logic [31:0] data_out);
    int cycles;
    cycles = 0;
    @(posedge CLK);
    bus_request <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: address, dat: data_in};
    @(posedge CLK);
    // Hold the request until ack shows up
    while (!bus_response.ack) begin
      if (cycles == BUS_TIMEOUT) report_timeout("Wishbone ack");
      @(posedge CLK);
      cycles++;
    end
    data_out = bus_response.dat;
    bus_request <= '0;
  endtask

  task automatic bus_write(wishbone_pkg::reg_address_e address, logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, address, data, unused);
  endtask

  task automatic bus_read(wishbone_pkg::reg_address_e address, output logic [31:0] data);
    bus_access(1'b0, address, '0, data);
  endtask

  // Poll STATUS until the sticky done bit is set
  task automatic wait_for_done();
    logic [31:0] status;
    int polls;
    status = '0;
    polls = 0;
    while (!status[1]) begin
      if (polls == POLL_LIMIT) report_timeout("the done bit in STATUS");
      bus_read(wishbone_pkg::REG_STATUS, status);
      polls++;
    end
  endtask

  task automatic launch(modular_pkg::mod_opcode_e opcode, logic [31:0] modulus,
                        logic [31:0] a, logic [31:0] b);
    bus_write(wishbone_pkg::REG_MODULUS, modulus);
    bus_write(wishbone_pkg::REG_OPERAND_A, a);
    bus_write(wishbone_pkg::REG_OPERAND_B, b);
    bus_write(wishbone_pkg::REG_CONTROL, {1'b1, 29'd0, opcode});
  endtask

  task automatic run_operation(string name, modular_pkg::mod_opcode_e opcode,
                               logic [31:0] modulus, logic [31:0] a, logic [31:0] b);
    logic [31:0] actual;
    launch(opcode, modulus, a, b);
    wait_for_done();
    bus_read(wishbone_pkg::REG_RESULT, actual);
    check_value(name, reference_result(opcode, modulus, a, b), actual);
  endtask

  // Modulus at least 2, operands reduced
  task automatic run_random(string name, modular_pkg::mod_opcode_e opcode);
    logic [31:0] m;
    logic [31:0] a;
    logic [31:0] b;
    m = next_random();
    if (m < 32'd2) m = 32'd2;
    a = next_random() % m;
    b = next_random() % m;
    run_operation(name, opcode, m, a, b);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    logic [31:0] data;
    logic [31:0] m;
    logic [31:0] a;
    logic [31:0] b;
    RST = 1'b1;
    bus_request = '0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    // Reset values, then register readback
    bus_read(wishbone_pkg::REG_STATUS, data);
    check_value("status after reset", 32'd0, data);
    bus_read(wishbone_pkg::REG_RESULT, data);
    check_value("result after reset", 32'd0, data);
    m = next_random();
    a = next_random();
    b = next_random();
    bus_write(wishbone_pkg::REG_MODULUS, m);
    bus_write(wishbone_pkg::REG_OPERAND_A, a);
    bus_write(wishbone_pkg::REG_OPERAND_B, b);
    bus_read(wishbone_pkg::REG_MODULUS, data);
    check_value("modulus readback", m, data);
    bus_read(wishbone_pkg::REG_OPERAND_A, data);
    check_value("operand_a readback", a, data);
    bus_read(wishbone_pkg::REG_OPERAND_B, data);
    check_value("operand_b readback", b, data);

    // Add and subtract, random plus wrap-around
    for (int i = 0; i < 8; i++) run_random("random add", modular_pkg::MOD_ADD);
    for (int i = 0; i < 8; i++) run_random("random sub", modular_pkg::MOD_SUB);
    m = next_random() | 32'd2;
    run_operation("add wrap", modular_pkg::MOD_ADD, m, m - 1, m - 1);
    run_operation("sub borrow", modular_pkg::MOD_SUB, m, 32'd0, m - 1);

    // Multiply with edge operands and moduli
    for (int i = 0; i < 6; i++) run_random("random mul", modular_pkg::MOD_MUL);
    run_operation("mul by zero", modular_pkg::MOD_MUL, m, 32'd0, m - 1);
    run_operation("mul by one", modular_pkg::MOD_MUL, m, 32'd1, m - 1);
    run_operation("mul max operands", modular_pkg::MOD_MUL, m, m - 1, m - 1);
    run_operation("mul modulus 2", modular_pkg::MOD_MUL, 32'd2, 32'd1, 32'd1);
    run_operation("mul modulus max", modular_pkg::MOD_MUL, 32'hFFFF_FFFF,
                  32'hFFFF_FFFE, 32'hFFFF_FFFE);

    // Exponentiation
    a = next_random() % m;
    run_operation("exp by zero", modular_pkg::MOD_EXP, m, a, 32'd0);
    run_operation("exp by one", modular_pkg::MOD_EXP, m, a, 32'd1);
    for (int i = 0; i < 3; i++) run_random("random exp", modular_pkg::MOD_EXP);

    // Launch while busy is dropped
    b = next_random() % m;
    launch(modular_pkg::MOD_MUL, m, a, b);
    bus_read(wishbone_pkg::REG_STATUS, data);
    check_value("status right after launch", 32'h1, data);
    bus_write(wishbone_pkg::REG_CONTROL, {1'b1, 29'd0, modular_pkg::MOD_ADD});
    wait_for_done();
    bus_read(wishbone_pkg::REG_STATUS, data);
    check_value("status once result ready", 32'h2, data);
    bus_read(wishbone_pkg::REG_RESULT, data);
    check_value("launch during busy", reference_result(modular_pkg::MOD_MUL, m, a, b), data);

    // Let the bound checks settle
    repeat (4) @(posedge CLK);
    if (modular_arithmetic_unit_i.assertions_i.failure_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- project.f
source/modular_pkg.sv
source/wishbone_pkg.sv
source/modular_register_file.sv
source/modular_sequencer.sv
source/scalar_modular_adder.sv
source/scalar_modular_multiplier.sv
source/modular_arithmetic_unit.sv
tb/modular_arithmetic_unit_assertions.sv
tb/modular_arithmetic_unit_tb.sv
